/* tb.f */
+incdir+.
commu_pkg.sv
commu_tx.sv
commu_rx.sv
commu_ctrl.sv
commu_top.sv
commu_chk.sv
commu_tb.sv

/* Bender.yml */
package:
  name: commu

export_include_dirs:
  - .

sources:
  - files:
      - commu_pkg.sv
      - commu_tx.sv
      - commu_rx.sv
      - commu_ctrl.sv
      - commu_top.sv
  - target: test
    files:
      - commu_chk.sv
      - commu_tb.sv

/* commu_tb.sv */
// testbench for the serial link top level
// clock, reset, serial line model, loopback tests and closing report
`include "commu_params.svh"

module commu_tb import commu_pkg::*; ();

	logic         clk_sys;
	logic         rst_n;
	logic         cfg_wr;
	period_t      cfg_period;
	logic         send;
	byte_t        send_data;
	logic         rx;
	logic         tx;
	host_status_t status;

	// rx pin from tx loopback or from the line model
	logic    loop_sel;
	logic    line_q;
	int      rx_seen;
	int      n_err;
	int      n_test;
	int      n_bad;
	int      err_mark;
	period_t cur_p;

	commu_top i_dut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cfg_wr     (cfg_wr),
		.cfg_period (cfg_period),
		.send       (send),
		.send_data  (send_data),
		.rx         (rx),
		.tx         (tx),
		.status     (status)
	);

	bind commu_top commu_chk i_chk (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fire_tx     (fire_tx),
		.done_tx     (done_tx),
		.tx          (tx),
		.send        (send),
		.tbit_period (tbit_period),
		.cfg_period  (cfg_period),
		.status      (status)
	);

	assign rx = loop_sel ? tx : line_q;

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	// good bytes seen by the host
	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			rx_seen <= 0;
		else if (status.rx_valid)
			rx_seen <= rx_seen + 1;
	end

	// ------------------------------------------------------------------------
	// helpers start and end just after a falling edge
	// ------------------------------------------------------------------------
	task automatic tick(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	function automatic int limit_cycles();
		return 30 * int'(cur_p) + 100;
	endfunction

	task automatic expect_val(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		assert (got === exp)
			else begin
				$display("FAIL %s expected %0h actual %0h", name, exp, got);
				n_err++;
			end
	endtask

	task automatic write_period(input period_t p);
		cfg_wr     = 1'b1;
		cfg_period = p;
		tick(1);
		cfg_wr = 1'b0;
		cur_p  = p;
	endtask

	task automatic send_byte(input byte_t b);
		send      = 1'b1;
		send_data = b;
		tick(1);
		send = 1'b0;
	endtask

	task automatic wait_rx(input int base, output byte_t data, output bit ok);
		int n;
		n    = 0;
		data = '0;
		while (rx_seen <= base && n < limit_cycles()) begin
			tick(1);
			n++;
		end
		ok = (rx_seen > base);
		if (ok) begin
			data = status.rx_data;
		end else begin
			$display("timeout: no byte reached the host within %0d cycles", n);
			n_err++;
		end
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (status.tx_busy && n < limit_cycles()) begin
			tick(1);
			n++;
		end
		if (status.tx_busy) begin
			$display("timeout: tx_busy still high after %0d cycles", n);
			n_err++;
		end
	endtask

	task automatic wait_err_change(input err_cnt_t base);
		int n;
		n = 0;
		while (status.err_cnt == base && n < limit_cycles()) begin
			tick(1);
			n++;
		end
		if (status.err_cnt == base) begin
			$display("timeout: framing error count did not move in %0d cycles", n);
			n_err++;
		end
	endtask

	// line model frame sent msb first with chosen stop levels
	task automatic drive_frame(input byte_t b, input logic stop_a, input logic stop_b);
		int i;
		line_q = 1'b0;
		tick(cur_p);
		for (i = `COMMU_DATA_W - 1; i >= 0; i--) begin
			line_q = b[i];
			tick(cur_p);
		end
		line_q = stop_a;
		tick(cur_p);
		line_q = stop_b;
		tick(cur_p);
		line_q = 1'b1;
	endtask

	task automatic loop_bytes(input string name, input int count);
		byte_t b;
		byte_t got;
		int    base;
		bit    ok;
		repeat (count) begin
			b    = byte_t'($urandom);
			base = rx_seen;
			send_byte(b);
			wait_rx(base, got, ok);
			if (ok)
				expect_val(name, b, got);
		end
	endtask

	// let the transmitter drain before the period or line changes
	task automatic settle();
		wait_not_busy();
		tick(2 * cur_p + 4);
	endtask

	task automatic end_test(input string name);
		n_test++;
		if (n_err == err_mark) begin
			$display("test %s ok", name);
		end else begin
			n_bad++;
			$display("test %s had %0d errors", name, n_err - err_mark);
		end
		err_mark = n_err;
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		byte_t    a;
		byte_t    b;
		byte_t    got;
		int       base;
		bit       ok;
		err_cnt_t err0;
		void'($urandom(32'h887f));
		rst_n      = 1'b0;
		cfg_wr     = 1'b0;
		cfg_period = period_t'(`COMMU_MIN_PERIOD);
		send       = 1'b0;
		send_data  = '0;
		loop_sel   = 1'b1;
		line_q     = 1'b1;
		cur_p      = period_t'(`COMMU_MIN_PERIOD);
		n_err      = 0;
		n_test     = 0;
		n_bad      = 0;
		err_mark   = 0;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		expect_val("reset_tx", 1, tx);
		expect_val("reset_busy", 0, status.tx_busy);
		expect_val("reset_valid", 0, status.rx_valid);
		expect_val("reset_err_cnt", 0, status.err_cnt);
		end_test("reset_state");

		write_period(8);
		loop_bytes("loopback_p8", 20);
		expect_val("loopback_err_cnt", 0, status.err_cnt);
		end_test("loopback_p8");

		// second send lands in the holding register
		settle();
		a    = byte_t'($urandom);
		b    = byte_t'($urandom);
		base = rx_seen;
		send_byte(a);
		send_byte(b);
		expect_val("hold_busy", 1, status.tx_busy);
		wait_rx(base, got, ok);
		if (ok)
			expect_val("hold_first", a, got);
		wait_not_busy();
		wait_rx(base + 1, got, ok);
		if (ok)
			expect_val("hold_second", b, got);
		end_test("holding_register");

		settle();
		write_period(13);
		loop_bytes("period_13", 8);
		settle();
		write_period(`COMMU_MIN_PERIOD);
		loop_bytes("period_min", 8);
		end_test("period_change");

		// second stop bit low
		settle();
		write_period(8);
		loop_sel = 1'b0;
		err0     = status.err_cnt;
		base     = rx_seen;
		drive_frame(byte_t'($urandom), 1'b1, 1'b0);
		wait_err_change(err0);
		expect_val("frame_err_cnt", err0 + 1'b1, status.err_cnt);
		tick(cur_p);
		expect_val("frame_err_valid", base, rx_seen);
		a    = byte_t'($urandom);
		base = rx_seen;
		drive_frame(a, 1'b1, 1'b1);
		wait_rx(base, got, ok);
		if (ok)
			expect_val("frame_err_next", a, got);
		end_test("framing_error");

		// low pulse well short of half a bit
		tick(cur_p);
		err0   = status.err_cnt;
		base   = rx_seen;
		line_q = 1'b0;
		tick(cur_p / 2 - 2);
		line_q = 1'b1;
		// long enough for a wrongly accepted frame to reach the host
		tick(12 * cur_p);
		expect_val("glitch_valid", base, rx_seen);
		expect_val("glitch_err_cnt", err0, status.err_cnt);
		a = byte_t'($urandom);
		drive_frame(a, 1'b1, 1'b1);
		wait_rx(base, got, ok);
		if (ok)
			expect_val("glitch_next", a, got);
		end_test("glitch_reject");

		tick(4 * cur_p);
		$display("summary: %0d tests run, %0d with errors, %0d failed checks, checker flag %0b",
			n_test, n_bad, n_err, i_dut.i_chk.chk_fail);
		if (n_err == 0 && !i_dut.i_chk.chk_fail) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* commu_chk.sv */
// bound assertions on the link top level
// idle line, frame length, start bit, host strobes and bit period
`include "commu_params.svh"

module commu_chk import commu_pkg::*; (
	input logic         clk_sys,
	input logic         rst_n,
	input logic         fire_tx,
	input logic         done_tx,
	input logic         tx,
	input logic         send,
	input period_t      tbit_period,
	input period_t      cfg_period,
	input host_status_t status
);

	// start bit, data bits and stop bits
	localparam int FRAME_BITS = 1 + `COMMU_DATA_W + `COMMU_STOP_BITS;

	logic        frame_on;
	logic [31:0] cyc_since;
	logic [31:0] frame_len;
	logic        bad_idle = 1'b0;
	logic        bad_len  = 1'b0;
	logic        bad_start = 1'b0;
	logic        bad_send = 1'b0;
	logic        bad_cfg  = 1'b0;
	logic        chk_fail;

	// frame tracker, period taken when the frame is fired
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			frame_on  <= 1'b0;
			cyc_since <= '0;
			frame_len <= '0;
		end else if (fire_tx) begin
			frame_on  <= 1'b1;
			cyc_since <= 32'd1;
			frame_len <= 32'(FRAME_BITS) * 32'(tbit_period) + 32'd1;
		end else if (done_tx) begin
			frame_on <= 1'b0;
		end else if (frame_on) begin
			cyc_since <= cyc_since + 32'd1;
		end
	end

	// ------------------------------------------------------------------------
	// properties
	// ------------------------------------------------------------------------
	a_idle_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!frame_on |-> tx)
		else begin
			$error("tx is low while no frame is being sent");
			bad_idle = 1'b1;
		end

	a_done_time: assert property (@(posedge clk_sys) disable iff (!rst_n)
		done_tx |-> (frame_on && cyc_since == frame_len))
		else begin
			$error("done_tx at cycle %0d of frame, expected %0d", cyc_since, frame_len);
			bad_len = 1'b1;
		end

	a_no_overrun: assert property (@(posedge clk_sys) disable iff (!rst_n)
		frame_on |-> cyc_since <= frame_len)
		else begin
			$error("frame runs past %0d cycles without done_tx", frame_len);
			bad_len = 1'b1;
		end

	a_start_low: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire_tx |=> !tx)
		else begin
			$error("tx not low on the cycle after fire_tx");
			bad_start = 1'b1;
		end

	a_send_free: assert property (@(posedge clk_sys) disable iff (!rst_n)
		send |-> !status.tx_busy)
		else begin
			$error("send strobe while tx_busy is high");
			bad_send = 1'b1;
		end

	a_cfg_min: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cfg_period >= period_t'(`COMMU_MIN_PERIOD))
		else begin
			$error("cfg_period %0d below the minimum bit period", cfg_period);
			bad_cfg = 1'b1;
		end

	assign chk_fail = bad_idle | bad_len | bad_start | bad_send | bad_cfg;

endmodule

/* commu_top.sv */
// top level of the serial link
// control module with transmitter and receiver on the two pins
module commu_top import commu_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  logic         cfg_wr,
	input  period_t      cfg_period,
	input  logic         send,
	input  byte_t        send_data,
	input  logic         rx,
	output logic         tx,
	output host_status_t status
);

	logic      fire_tx;
	logic      done_tx;
	byte_t     data_tx;
	period_t   tbit_period;
	logic      rx_done;
	rx_frame_t rx_frame;

	commu_ctrl i_ctrl (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.cfg_wr      (cfg_wr),
		.cfg_period  (cfg_period),
		.send        (send),
		.send_data   (send_data),
		.done_tx     (done_tx),
		.rx_done     (rx_done),
		.rx_frame    (rx_frame),
		.fire_tx     (fire_tx),
		.data_tx     (data_tx),
		.tbit_period (tbit_period),
		.status      (status)
	);

	commu_tx i_tx (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fire_tx     (fire_tx),
		.data_tx     (data_tx),
		.tbit_period (tbit_period),
		.done_tx     (done_tx),
		.tx          (tx)
	);

	// receiver shares the programmed bit period
	commu_rx i_rx (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rx          (rx),
		.tbit_period (tbit_period),
		.rx_done     (rx_done),
		.rx_frame    (rx_frame)
	);

endmodule

/* commu_ctrl.sv */
// link control: period register, transmit holding register and sequencer
// receive result latch and saturating framing-error counter
`include "commu_params.svh"

module commu_ctrl import commu_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  logic         cfg_wr,
	input  period_t      cfg_period,
	input  logic         send,
	input  byte_t        send_data,
	input  logic         done_tx,
	input  logic         rx_done,
	input  rx_frame_t    rx_frame,
	output logic         fire_tx,
	output byte_t        data_tx,
	output period_t      tbit_period,
	output host_status_t status
);

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	period_t     period_q;
	byte_t       data_q;
	byte_t       hold_q;
	logic        hold_full;
	logic        take_send;
	logic        take_hold;
	logic        fill_hold;
	logic        rx_valid_q;
	byte_t       rx_data_q;
	err_cnt_t    err_cnt_q;

	// bit period, host writes it only between frames
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			period_q <= period_t'(`COMMU_MIN_PERIOD);
		else if (cfg_wr)
			period_q <= cfg_period;
	end

	// ------------------------------------------------------------------------
	// transmit sequencer
	// ------------------------------------------------------------------------
	// a send goes straight out if the transmitter is free this cycle
	assign take_send = send && ((state == C_IDLE) ||
		(state == C_WAIT && done_tx && !hold_full));
	assign take_hold = (state == C_WAIT) && done_tx && hold_full;
	assign fill_hold = send && !take_send;

	always_comb begin
		state_nxt = state;
		case (state)
			C_IDLE: begin
				if (take_send)
					state_nxt = C_FIRE;
			end
			C_FIRE: state_nxt = C_WAIT;
			C_WAIT: begin
				if (take_send || take_hold)
					state_nxt = C_FIRE;
				else if (done_tx)
					state_nxt = C_IDLE;
			end
			default: state_nxt = C_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state     <= C_IDLE;
			hold_full <= 1'b0;
		end else begin
			state <= state_nxt;
			if (fill_hold)
				hold_full <= 1'b1;
			else if (take_hold)
				hold_full <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take_send)
			data_q <= send_data;
		else if (take_hold)
			data_q <= hold_q;
		if (fill_hold)
			hold_q <= send_data;
	end

	// ------------------------------------------------------------------------
	// receive side
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_valid_q <= 1'b0;
			rx_data_q  <= '0;
			err_cnt_q  <= '0;
		end else begin
			rx_valid_q <= rx_done && !rx_frame.frame_err;
			if (rx_done && !rx_frame.frame_err)
				rx_data_q <= rx_frame.data;
			// count sticks at all ones
			if (rx_done && rx_frame.frame_err && err_cnt_q != '1)
				err_cnt_q <= err_cnt_q + 1'b1;
		end
	end

	assign fire_tx     = (state == C_FIRE);
	assign data_tx     = data_q;
	assign tbit_period = period_q;
	assign status      = '{tx_busy: hold_full, rx_valid: rx_valid_q,
		rx_data: rx_data_q, err_cnt: err_cnt_q};

endmodule

/* commu_rx.sv */
// serial receiver with input synchronizer and half-bit start check
// mid-bit data sampling, msb first, and stop-bit framing check
`include "commu_params.svh"

module commu_rx import commu_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      rx,
	input  period_t   tbit_period,
	output logic      rx_done,
	output rx_frame_t rx_frame
);

	localparam int IDX_W     = $clog2(`COMMU_DATA_W);
	localparam int LAST_STOP = `COMMU_STOP_BITS - 1;

	logic [1:0]       rx_sync;
	logic             rx_line;
	logic             rx_prev;
	logic             fall;
	rx_state_e        state;
	period_t          cnt_cycle;
	period_t          half_period;
	logic             half_hit;
	logic             bit_hit;
	logic             cnt_clr;
	logic [IDX_W-1:0] bit_idx;
	byte_t            shift_q;
	logic             stop_err;

	// ------------------------------------------------------------------------
	// input synchronizer and edge detect
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_prev <= rx_line;
		end
	end

	assign rx_line = rx_sync[1];
	assign fall    = rx_prev && !rx_line;

	// ------------------------------------------------------------------------
	// sample timer
	// ------------------------------------------------------------------------
	assign half_period = tbit_period >> 1;
	assign half_hit    = (cnt_cycle == half_period - period_t'(1));
	assign bit_hit     = (cnt_cycle == tbit_period - period_t'(1));

	// restart at each sample point, hold at zero outside a frame
	always_comb begin
		case (state)
			RX_START:         cnt_clr = half_hit;
			RX_DATA, RX_STOP: cnt_clr = bit_hit;
			default:          cnt_clr = 1'b1;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_cycle <= '0;
		else if (cnt_clr)
			cnt_cycle <= '0;
		else
			cnt_cycle <= cnt_cycle + period_t'(1);
	end

	// ------------------------------------------------------------------------
	// receive FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state   <= RX_IDLE;
			bit_idx <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					if (fall)
						state <= RX_START;
				end
				// line back high at half a bit means a glitch
				RX_START: begin
					if (half_hit) begin
						state   <= rx_line ? RX_IDLE : RX_DATA;
						bit_idx <= '0;
					end
				end
				RX_DATA: begin
					if (bit_hit) begin
						if (bit_idx == IDX_W'(`COMMU_DATA_W - 1)) begin
							state   <= RX_STOP;
							bit_idx <= '0;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				RX_STOP: begin
					if (bit_hit) begin
						if (bit_idx == IDX_W'(LAST_STOP))
							state <= RX_DONE;
						else
							bit_idx <= bit_idx + 1'b1;
					end
				end
				RX_DONE: state <= RX_IDLE;
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data shifts in from the lsb end, first sample ends up in the msb
	always_ff @(posedge clk_sys) begin
		if (state == RX_DATA && bit_hit)
			shift_q <= {shift_q[`COMMU_DATA_W-2:0], rx_line};
		if (state == RX_START && half_hit)
			stop_err <= 1'b0;
		else if (state == RX_STOP && bit_hit && !rx_line)
			stop_err <= 1'b1;
	end

	assign rx_done  = (state == RX_DONE);
	assign rx_frame = '{data: shift_q, frame_err: stop_err};

endmodule

/* commu_tx.sv */
// serial transmitter with start bit, msb-first data and stop bits
// bit timing from a cycle counter that wraps at the bit period
`include "commu_params.svh"

module commu_tx import commu_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n,
	input  logic    fire_tx,
	input  byte_t   data_tx,
	input  period_t tbit_period,
	output logic    done_tx,
	output logic    tx
);

	localparam int IDX_W     = $clog2(`COMMU_DATA_W);
	localparam int LAST_STOP = `COMMU_STOP_BITS - 1;

	tx_state_e        state;
	byte_t            data_q;
	period_t          cnt_cycle;
	logic [IDX_W-1:0] bit_idx;
	logic             send_bit;
	logic             finish_bit;

	// byte is captured only when a frame starts
	always_ff @(posedge clk_sys) begin
		if (state == TX_IDLE && fire_tx)
			data_q <= data_tx;
	end

	// ------------------------------------------------------------------------
	// main FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state   <= TX_IDLE;
			bit_idx <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (fire_tx)
						state <= TX_START;
				end
				TX_START: begin
					if (finish_bit) begin
						state   <= TX_DATA;
						bit_idx <= IDX_W'(`COMMU_DATA_W - 1);
					end
				end
				// index counts down through the data bits
				TX_DATA: begin
					if (finish_bit) begin
						if (bit_idx == '0) begin
							state <= TX_STOP;
						end else begin
							bit_idx <= bit_idx - 1'b1;
						end
					end
				end
				// and up through the stop bits
				TX_STOP: begin
					if (finish_bit) begin
						if (bit_idx == IDX_W'(LAST_STOP)) begin
							state <= TX_DONE;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				TX_DONE: state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// bit timer
	// ------------------------------------------------------------------------
	assign send_bit   = (state != TX_IDLE) && (state != TX_DONE);
	assign finish_bit = send_bit && (cnt_cycle == tbit_period - period_t'(1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_cycle <= '0;
		else if (!send_bit || finish_bit)
			cnt_cycle <= '0;
		else
			cnt_cycle <= cnt_cycle + period_t'(1);
	end

	// line level, high outside a frame
	always_comb begin
		case (state)
			TX_START: tx = 1'b0;
			TX_DATA:  tx = data_q[bit_idx];
			default:  tx = 1'b1;
		endcase
	end

	assign done_tx = (state == TX_DONE);

endmodule

/* commu_pkg.sv */
// shared types of the serial link
// vector typedefs, FSM state enums and the packed status structs
`include "commu_params.svh"

package commu_pkg;

	// ------------------------------------------------------------------------
	// vectors
	// ------------------------------------------------------------------------
	typedef logic [`COMMU_DATA_W-1:0]   byte_t;
	typedef logic [`COMMU_PERIOD_W-1:0] period_t;
	// saturating count of bad frames
	typedef logic [7:0]                 err_cnt_t;

	// ------------------------------------------------------------------------
	// state machines
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP,
		TX_DONE
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_DONE
	} rx_state_e;

	typedef enum logic [1:0] {
		C_IDLE,
		C_FIRE,
		C_WAIT
	} ctrl_state_e;

	// ------------------------------------------------------------------------
	// bundles
	// ------------------------------------------------------------------------
	typedef struct packed {
		byte_t data;
		logic  frame_err;
	} rx_frame_t;

	typedef struct packed {
		logic     tx_busy;
		logic     rx_valid;
		byte_t    rx_data;
		err_cnt_t err_cnt;
	} host_status_t;

endpackage

/* commu_params.svh */
// frame and timing constants of the serial link
// data width, bit-period counter width, stop bits, minimum bit period
`ifndef COMMU_PARAMS_SVH
`define COMMU_PARAMS_SVH

// ---------------------------------------------------------------------------
// frame layout
// ---------------------------------------------------------------------------

// payload bits per frame, sent msb first
`define COMMU_DATA_W 8

// stop bits at the end of a frame, always high on the line
`define COMMU_STOP_BITS 2

// ---------------------------------------------------------------------------
// bit timing
// ---------------------------------------------------------------------------

// bit-period counter, up to about one million cycles per bit
`define COMMU_PERIOD_W 20

// half a bit must still leave two cycles for the start check
`define COMMU_MIN_PERIOD 4

`endif
